/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_hdc_core
FILELIST  = all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

/* all.f */
+incdir+.
hdc_pkg.sv
item_memory.sv
instr_dispatch.sv
thread_lane.sv
result_collector.sv
hdc_core.sv
tb_clock.sv
tb_hdc_core.sv

/* hdc_config.svh */
`ifndef HDC_CONFIG_SVH
`define HDC_CONFIG_SVH

// hypervector width, one bus word
`define HDC_VEC_W 32

// item memory geometry
`define HDC_ITEM_DEPTH 64
`define HDC_ITEM_AW 6

// thread lanes
`define HDC_THREADS 4
`define HDC_THREAD_W 2

// wishbone word address, bit 6 picks item memory writes
`define HDC_ADR_W 7
`define HDC_ITEM_SEL 6

// instruction word layout
`define HDC_INSTR_W 16
`define HDC_OP_W 4
`define HDC_OP_HI 15
`define HDC_OP_LO 12
`define HDC_TID_HI 11
`define HDC_TID_LO 10

`endif

/* hdc_core.sv */
`default_nettype none

`include "hdc_config.svh"

module hdc_core
    import hdc_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,

    // wishbone classic slave
    input  wire logic                  wb_cyc,
    input  wire logic                  wb_stb,
    input  wire logic                  wb_we,
    input  wire logic [`HDC_ADR_W-1:0] wb_adr,
    input  wire logic [`HDC_VEC_W-1:0] wb_dat_w,
    output logic                       wb_ack,

    // results
    output hv_t                        result,
    output logic                       store,
    output logic                       last
);

    // item memory ports
    item_wr_t               bus_wr;
    item_wr_t               wb_wr;
    item_addr_t             rd_addr;
    hv_t                    rd_data;

    // broadcast and lane outputs
    issue_t                 issue;
    hv_t [`HDC_THREADS-1:0] lane_r2;

    // bus slave and decode
    instr_dispatch u_dispatch (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .item_wr  (bus_wr),
        .rd_addr  (rd_addr),
        .issue    (issue)
    );

    item_memory u_item_mem (
        .clk     (clk),
        .bus_wr  (bus_wr),
        .wb_wr   (wb_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // one context per thread, all see the same broadcast
    for (genvar i = 0; i < `HDC_THREADS; i++) begin : g_lane
        thread_lane u_lane (
            .clk       (clk),
            .reset     (reset),
            .en        (issue.lane_en[i]),
            .issue     (issue),
            .item_data (rd_data),
            .r2        (lane_r2[i])
        );
    end

    // store, last and write-back
    result_collector u_collector (
        .clk     (clk),
        .reset   (reset),
        .issue   (issue),
        .lane_r2 (lane_r2),
        .wb_wr   (wb_wr),
        .result  (result),
        .store   (store),
        .last    (last)
    );

endmodule

`default_nettype wire

/* hdc_pkg.sv */
`default_nettype none

`include "hdc_config.svh"

package hdc_pkg;

    // one binary hypervector
    typedef logic [`HDC_VEC_W-1:0] hv_t;

    // item memory word address
    typedef logic [`HDC_ITEM_AW-1:0] item_addr_t;

    // thread context index
    typedef logic [`HDC_THREAD_W-1:0] thread_id_t;

    // rotate amount, 0 .. width-1
    typedef logic [$clog2(`HDC_VEC_W)-1:0] shift_t;

    // raw 16-bit instruction as written over the bus
    typedef logic [`HDC_INSTR_W-1:0] instr_t;

    // opcodes, codes 8..15 decode to NOP
    typedef enum logic [`HDC_OP_W-1:0] {
        NOP   = 4'd0,
        LOAD  = 4'd1,
        XOR   = 4'd2,
        MOVE  = 4'd3,
        PERM  = 4'd4,
        STORE = 4'd5,
        WB    = 4'd6,
        LAST  = 4'd7
    } hdc_op_e;

    // broadcast to all lanes and the collector, op valid one cycle
    typedef struct packed {
        hdc_op_e                 op;
        logic [`HDC_THREADS-1:0] lane_en;
        item_addr_t              addr;
        shift_t                  shift;
    } issue_t;

    // single item memory write port
    typedef struct packed {
        logic       we;
        item_addr_t addr;
        hv_t        data;
    } item_wr_t;

endpackage

`default_nettype wire

/* instr_dispatch.sv */
`default_nettype none

`include "hdc_config.svh"

module instr_dispatch
    import hdc_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    reset,

    // wishbone classic slave, write only in effect
    input  wire logic                    wb_cyc,
    input  wire logic                    wb_stb,
    input  wire logic                    wb_we,
    input  wire logic [`HDC_ADR_W-1:0]   wb_adr,
    input  wire logic [`HDC_VEC_W-1:0]   wb_dat_w,
    output logic                         wb_ack,

    // item load from the host
    output item_wr_t                     item_wr,

    // read address for LOAD, memory registers it
    output item_addr_t                   rd_addr,

    // issued instruction, broadcast
    output issue_t                       issue
);

    // transfer handshake
    logic                    req;
    logic                    wr_acc;
    logic                    instr_acc;

    // instruction fields
    instr_t                  instr;
    logic [`HDC_OP_W-1:0]    op_raw;
    thread_id_t              tid;
    hdc_op_e                 op_dec;
    logic [`HDC_THREADS-1:0] lane_dec;

    // issue registers
    hdc_op_e                 op_q;
    logic [`HDC_THREADS-1:0] lane_en_q;
    item_addr_t              addr_q;
    shift_t                  shift_q;

    // new request only while ack is low
    // reads get acked too but change nothing
    assign req       = wb_cyc & wb_stb & ~wb_ack;
    assign wr_acc    = req & wb_we;
    assign instr_acc = wr_acc & ~wb_adr[`HDC_ITEM_SEL];

    // item write goes straight to memory at the accept edge
    assign item_wr = '{
        we:   wr_acc & wb_adr[`HDC_ITEM_SEL],
        addr: wb_adr[`HDC_ITEM_AW-1:0],
        data: wb_dat_w
    };

    // low half of the data word is the instruction
    assign instr  = wb_dat_w[`HDC_INSTR_W-1:0];
    assign op_raw = instr[`HDC_OP_HI:`HDC_OP_LO];
    assign tid    = instr[`HDC_TID_HI:`HDC_TID_LO];

    // top opcode bit set means 8..15, all unused
    assign op_dec = op_raw[`HDC_OP_W-1] ? NOP : hdc_op_e'(op_raw);

    // start the item read in the same cycle
    // only LOAD cares about the data
    assign rd_addr = instr[`HDC_ITEM_AW-1:0];

    // thread field to one-hot lane select
    always_comb begin
        lane_dec      = '0;
        lane_dec[tid] = 1'b1;
    end

    // ack and issue valid for exactly one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            op_q      <= NOP;
            lane_en_q <= '0;
        end
        else begin
            wb_ack <= req;
            if (instr_acc) begin
                op_q      <= op_dec;
                lane_en_q <= lane_dec;
            end
            else begin
                op_q      <= NOP;
                lane_en_q <= '0;
            end
        end
    end

    // operand payload, only meaningful alongside op
    always_ff @(posedge clk) begin
        if (instr_acc) begin
            addr_q  <= instr[`HDC_ITEM_AW-1:0];
            shift_q <= instr[$bits(shift_t)-1:0];
        end
    end

    assign issue = '{
        op:      op_q,
        lane_en: lane_en_q,
        addr:    addr_q,
        shift:   shift_q
    };

endmodule

`default_nettype wire

/* item_memory.sv */
`default_nettype none

`include "hdc_config.svh"

module item_memory
    import hdc_pkg::*;
(
    input  wire logic     clk,

    // host write from the bus
    input  item_wr_t      bus_wr,

    // write-back from a lane
    input  item_wr_t      wb_wr,

    // registered read, data one cycle later
    input  item_addr_t    rd_addr,
    output hv_t           rd_data
);

    // item store, contents left uninitialized
    hv_t mem [`HDC_ITEM_DEPTH];

    always_ff @(posedge clk) begin
        // write-back wins over the bus
        // bus spacing keeps both from landing on one edge anyway
        if (wb_wr.we) begin
            mem[wb_wr.addr] <= wb_wr.data;
        end
        else if (bus_wr.we) begin
            mem[bus_wr.addr] <= bus_wr.data;
        end

        // read every cycle, lanes only sample it on LOAD
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* result_collector.sv */
`default_nettype none

`include "hdc_config.svh"

module result_collector
    import hdc_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,

    // broadcast instruction
    input  issue_t                      issue,

    // r2 of every lane
    input  hv_t [`HDC_THREADS-1:0]      lane_r2,

    // write-back into item memory
    output item_wr_t                    wb_wr,

    // store port
    output hv_t                         result,
    output logic                        store,

    // end of program
    output logic                        last
);

    // r2 of the addressed lane
    hv_t sel_r2;

    // lane_en is one-hot or zero, so OR the masked lanes
    always_comb begin
        sel_r2 = '0;
        for (int i = 0; i < `HDC_THREADS; i++) begin
            if (issue.lane_en[i]) begin
                sel_r2 = sel_r2 | lane_r2[i];
            end
        end
    end

    // WB lands at the same edge the lanes update
    // so memory gets the old r2
    assign wb_wr = '{
        we:   issue.op == WB,
        addr: issue.addr,
        data: sel_r2
    };

    // strobes high one cycle, result zero outside store
    always_ff @(posedge clk) begin
        if (reset) begin
            store  <= 1'b0;
            last   <= 1'b0;
            result <= '0;
        end
        else begin
            store  <= issue.op == STORE;
            last   <= issue.op == LAST;
            result <= (issue.op == STORE) ? sel_r2 : '0;
        end
    end

endmodule

`default_nettype wire

/* tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    localparam int HALF_PERIOD = 5;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset seen by the design on the first 8 rising edges
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb_hdc_core.sv */
`default_nettype none

`include "hdc_config.svh"

module tb_hdc_core;

    timeunit 1ns;
    timeprecision 100ps;

    // opcodes as the instruction format defines them
    localparam logic [3:0] OP_LOAD  = 4'd1;
    localparam logic [3:0] OP_XOR   = 4'd2;
    localparam logic [3:0] OP_MOVE  = 4'd3;
    localparam logic [3:0] OP_PERM  = 4'd4;
    localparam logic [3:0] OP_STORE = 4'd5;
    localparam logic [3:0] OP_WB    = 4'd6;
    localparam logic [3:0] OP_LAST  = 4'd7;

    // what a row should make visible two cycles after acceptance
    localparam logic [1:0] K_NONE  = 2'd0;
    localparam logic [1:0] K_STORE = 2'd1;
    localparam logic [1:0] K_LAST  = 2'd2;

    // item vectors
    localparam logic [`HDC_VEC_W-1:0] VEC_X = 32'h9e3779b9;
    localparam logic [`HDC_VEC_W-1:0] VEC_A = 32'hc3a5f00f;
    localparam logic [`HDC_VEC_W-1:0] VEC_B = 32'h5a17e6d2;
    localparam logic [`HDC_VEC_W-1:0] VEC_C = 32'h0f1e2d3c;

    // one bus write and its expected outcome
    typedef struct packed {
        logic [`HDC_ADR_W-1:0] adr;
        logic [`HDC_VEC_W-1:0] dat;
        logic [1:0]            kind;
        logic [`HDC_VEC_W-1:0] want;
    } row_t;

    logic                  clk;
    logic                  reset;

    // bus master side
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`HDC_ADR_W-1:0] wb_adr;
    logic [`HDC_VEC_W-1:0] wb_dat_w;
    logic                  wb_ack;

    // DUT outputs
    logic [`HDC_VEC_W-1:0] result;
    logic                  store;
    logic                  last;

    row_t                  rows[$];
    row_t                  cur;

    // monitor pipeline, stage 2 is checked
    row_t                  s1;
    row_t                  s2;
    logic                  s1_valid;
    logic                  s2_valid;
    logic                  after_reset;

    int                    mismatches = 0;
    int                    others = 0;
    int                    cycles = 0;
    int                    timeout_limit;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    hdc_core uut (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .result   (result),
        .store    (store),
        .last     (last)
    );

    // bit n of the input lands at bit n+amt, wrapping
    function automatic logic [`HDC_VEC_W-1:0] rotate_left(
        input logic [`HDC_VEC_W-1:0] v,
        input int amt
    );
        logic [`HDC_VEC_W-1:0] out;
        out = '0;
        for (int i = 0; i < `HDC_VEC_W; i++) begin
            out[(i + amt) % `HDC_VEC_W] = v[i];
        end
        return out;
    endfunction

    task automatic check_value(
        input string name,
        input logic [`HDC_VEC_W-1:0] got,
        input logic [`HDC_VEC_W-1:0] want
    );
        if (got !== want) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
            mismatches++;
        end
    endtask

    // bit 6 of the address selects item memory
    task automatic item_row(input int addr, input logic [`HDC_VEC_W-1:0] data);
        row_t r;
        r.adr  = {1'b1, addr[5:0]};
        r.dat  = data;
        r.kind = K_NONE;
        r.want = '0;
        rows.push_back(r);
    endtask

    task automatic instr_row(
        input logic [3:0] op,
        input int tid,
        input int operand,
        input logic [1:0] kind,
        input logic [`HDC_VEC_W-1:0] want
    );
        row_t r;
        r.adr  = '0;
        r.dat  = {16'h0, op, tid[1:0], operand[9:0]};
        r.kind = kind;
        r.want = want;
        rows.push_back(r);
    endtask

    task automatic fill_table();
        // item X at 5, load and store on thread 0
        item_row(5, VEC_X);
        instr_row(OP_LOAD, 0, 5, K_NONE, '0);
        instr_row(OP_STORE, 0, 0, K_STORE, VEC_X);

        // bind on thread 1
        item_row(1, VEC_A);
        item_row(2, VEC_B);
        instr_row(OP_LOAD, 1, 1, K_NONE, '0);
        instr_row(OP_MOVE, 1, 0, K_NONE, '0);
        instr_row(OP_LOAD, 1, 2, K_NONE, '0);
        instr_row(OP_XOR, 1, 0, K_NONE, '0);
        instr_row(OP_STORE, 1, 0, K_STORE, VEC_A ^ VEC_B);

        // permute on thread 0, 7 then 25 wraps back to A
        instr_row(OP_LOAD, 0, 1, K_NONE, '0);
        instr_row(OP_PERM, 0, 7, K_NONE, '0);
        instr_row(OP_STORE, 0, 0, K_STORE, rotate_left(VEC_A, 7));
        instr_row(OP_PERM, 0, 25, K_NONE, '0);
        instr_row(OP_STORE, 0, 0, K_STORE, VEC_A);

        // thread 2 work, then 3 and 1 must be untouched
        item_row(3, VEC_C);
        instr_row(OP_LOAD, 2, 3, K_NONE, '0);
        instr_row(OP_MOVE, 2, 0, K_NONE, '0);
        instr_row(OP_PERM, 2, 3, K_NONE, '0);
        instr_row(OP_XOR, 2, 0, K_NONE, '0);
        instr_row(OP_STORE, 2, 0, K_STORE, VEC_C ^ rotate_left(VEC_C, 3));
        instr_row(OP_STORE, 3, 0, K_STORE, '0);
        instr_row(OP_STORE, 1, 0, K_STORE, VEC_A ^ VEC_B);

        // thread 1 r2 into item 9, read back through thread 0
        instr_row(OP_WB, 1, 9, K_NONE, '0);
        instr_row(OP_LOAD, 0, 9, K_NONE, '0);
        instr_row(OP_STORE, 0, 0, K_STORE, VEC_A ^ VEC_B);

        // end of program
        instr_row(OP_LAST, 0, 0, K_LAST, '0);
    endtask

    // called on a rising edge, returns on the edge after the idle cycle
    task automatic bus_write(input row_t r);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= r.adr;
        wb_dat_w <= r.dat;
        cur      <= r;
        @(posedge clk);
        while (wb_ack !== 1'b1) begin
            @(posedge clk);
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(posedge clk);
    endtask

    // outputs sampled at the edge, i.e. values of the cycle before
    always @(posedge clk) begin
        if (reset) begin
            s1_valid    = 1'b0;
            s2_valid    = 1'b0;
            after_reset = 1'b1;
        end
        else begin
            // first cycle out of reset
            if (after_reset) begin
                check_value("wb_ack", 32'(wb_ack), '0);
                check_value("store", 32'(store), '0);
                check_value("last", 32'(last), '0);
                check_value("result", result, '0);
                after_reset = 1'b0;
            end
            if (s2_valid) begin
                check_value("store", 32'(store), 32'(s2.kind == K_STORE));
                check_value("last", 32'(last), 32'(s2.kind == K_LAST));
                check_value("result", result, (s2.kind == K_STORE) ? s2.want : '0);
            end
            else begin
                if (store === 1'b1) begin
                    $display("ERROR at %0t: store pulsed with no transfer two cycles earlier",
                             $time);
                    others++;
                end
                if (last === 1'b1) begin
                    $display("ERROR at %0t: last pulsed with no transfer two cycles earlier",
                             $time);
                    others++;
                end
                check_value("result", result, '0);
            end
            // advance, then note a transfer accepted this cycle
            s2       = s1;
            s2_valid = s1_valid;
            s1       = cur;
            s1_valid = wb_cyc & wb_stb & wb_we & ~wb_ack;
        end
    end

    // run limit from the table length
    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_limit) begin
            $display("timeout after %0d cycles, a transfer was never acknowledged", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        cur      = '0;
        s1       = '0;
        s2       = '0;
        fill_table();
        timeout_limit = rows.size() * 6 + 100;

        // first edge with reset already released
        @(posedge clk);
        while (reset !== 1'b0) begin
            @(posedge clk);
        end

        foreach (rows[i]) begin
            bus_write(rows[i]);
        end

        // let the monitor see the last row
        repeat (3) @(posedge clk);

        $display("errors: %0d mismatches, %0d other failures", mismatches, others);
        if (mismatches == 0 && others == 0) begin
            $display("PASS: all tests");
        end
        else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* thread_lane.sv */
`default_nettype none

`include "hdc_config.svh"

module thread_lane
    import hdc_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,

    // this lane's bit of lane_en
    input  wire logic en,

    // broadcast instruction
    input  issue_t    issue,

    // item memory read data, valid while issue is
    input  hv_t       item_data,

    // context register r2, read by the collector
    output hv_t       r2
);

    // context register r1, bind operand
    hv_t r1;

    // rotate through a doubled copy
    logic [2*`HDC_VEC_W-1:0] dbl;
    hv_t                     rot;

    // upper half of the shifted pair is r2 rotated left
    assign dbl = {r2, r2} << issue.shift;
    assign rot = dbl[2*`HDC_VEC_W-1:`HDC_VEC_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            r1 <= '0;
            r2 <= '0;
        end
        else if (en) begin
            case (issue.op)
                // fetch item
                LOAD: begin
                    r2 <= item_data;
                end
                // bind
                XOR: begin
                    r2 <= r1 ^ r2;
                end
                // keep r2 as the next bind operand
                MOVE: begin
                    r1 <= r2;
                end
                // permute
                PERM: begin
                    r2 <= rot;
                end
                // STORE, WB, LAST read r2 elsewhere
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire
